/* source/acc_consts.svh */
// --------------------------------------------------
// Image geometry and memory map for the accelerator
// Line length must be a multiple of 4 and at least 8
// Line count must be at least 3
// Result image starts right after the source image
// --------------------------------------------------
`ifndef ACC_CONSTS_SVH
`define ACC_CONSTS_SVH

// Image size in pixels
`define ACC_LINE_LENGTH 16
`define ACC_LINE_COUNT 8

// Four pixels per 32-bit memory word
`define ACC_WORDS_PER_LINE (`ACC_LINE_LENGTH / 4)

// First word of the result region
`define ACC_WRITEBACK_ADDR (`ACC_WORDS_PER_LINE * `ACC_LINE_COUNT)

// Greyscale depth
`define ACC_PIXEL_BITS 8

`endif

/* source/acc_pkg.sv */
// --------------------------------------------------
// Shared types for the Sobel accelerator
// Pixel 0 of a memory word is its low byte
// --------------------------------------------------
`include "acc_consts.svh"

package acc_pkg;

  // One memory word, seen whole or as four pixels
  typedef union packed {
    logic [4*`ACC_PIXEL_BITS-1:0]    word;
    logic [3:0][`ACC_PIXEL_BITS-1:0] pix;  // pix[0] is leftmost
  } pixel_word_t;

  // Line slot in the three-line ring, 0 to 2
  typedef logic [1:0] slot_t;

  // Word position inside one image line
  typedef logic [$clog2(`ACC_WORDS_PER_LINE)-1:0] word_idx_t;

  // Neighbourhood of one output word
  // Row 0 is the top line, column 0 the left neighbour
  typedef logic [2:0][5:0][`ACC_PIXEL_BITS-1:0] window_t;

endpackage

/* source/acc_control.sv */
// --------------------------------------------------
// Sequencer for loads, result writes and ring rotation
// Memory must accept one access per cycle
// Read data is expected one cycle after the address
// All counters restart on every start
// --------------------------------------------------
`timescale 1ns/1ps
`include "acc_consts.svh"

module acc_control (
  input  logic               clk,
  input  logic               reset,
  input  logic               start,
  output logic [15:0]        addr,
  output logic               en,
  output logic               we,
  output logic               finish,
  output logic               buf_wr_en,
  output acc_pkg::slot_t     buf_wr_slot,
  output acc_pkg::word_idx_t buf_word_idx,
  output logic               first_line,
  output logic               last_line,
  output acc_pkg::slot_t     top_slot
);

  // --------------------------------------------------
  // State encoding
  // --------------------------------------------------
  localparam logic [2:0] S_IDLE = 3'd0;
  localparam logic [2:0] S_LOAD = 3'd1;  // First two lines
  localparam logic [2:0] S_PROC = 3'd2;  // One output line of writes
  localparam logic [2:0] S_GAP  = 3'd3;  // Bus turnaround
  localparam logic [2:0] S_READ = 3'd4;  // Refill oldest slot
  localparam logic [2:0] S_DONE = 3'd5;

  localparam int LINE_BITS = $clog2(`ACC_LINE_COUNT);
  localparam logic [LINE_BITS-1:0] PRE_LAST = LINE_BITS'(`ACC_LINE_COUNT - 2);
  localparam acc_pkg::word_idx_t LAST_WORD =
    acc_pkg::word_idx_t'(`ACC_WORDS_PER_LINE - 1);
  localparam logic [15:0] WB_ADDR = 16'(`ACC_WRITEBACK_ADDR);

  logic [2:0]           state, state_nx;
  logic [15:0]          rd_addr, rd_addr_nx;     // Next source word
  logic [15:0]          wr_addr, wr_addr_nx;     // Next result word
  acc_pkg::word_idx_t   word_cnt, word_cnt_nx;   // Issue / process position
  logic [LINE_BITS-1:0] line_cnt, line_cnt_nx;   // Output lines done
  acc_pkg::slot_t       top_nx;
  logic                 last_nx;
  acc_pkg::slot_t       ld_slot, ld_slot_nx;     // Slot the issued read lands in
  logic                 ld_first, ld_first_nx;   // Issued read belongs to line 0
  acc_pkg::word_idx_t   st_word;                 // Word being stored this cycle
  logic                 rd_issue;
  logic                 load_done;

  // Ring advance from top to mid to bot
  function automatic acc_pkg::slot_t rotate(input acc_pkg::slot_t s);
    return (s == 2'd2) ? 2'd0 : s + 2'd1;
  endfunction

  assign addr      = we ? wr_addr : rd_addr;
  assign rd_issue  = en && !we;
  // Last word of line 1 or of a refill lands this cycle
  assign load_done = buf_wr_en && (st_word == LAST_WORD) && !first_line;
  // Stores use the delayed index and result writes the live one
  assign buf_word_idx = buf_wr_en ? st_word : word_cnt;

  // --------------------------------------------------
  // Next-state and bus strobes
  // --------------------------------------------------
  always_comb begin
    state_nx    = state;
    rd_addr_nx  = rd_addr;
    wr_addr_nx  = wr_addr;
    word_cnt_nx = word_cnt;
    line_cnt_nx = line_cnt;
    top_nx      = top_slot;
    last_nx     = last_line;
    ld_slot_nx  = ld_slot;
    ld_first_nx = ld_first;
    en          = 1'b0;
    we          = 1'b0;
    finish      = 1'b0;

    case (state)
      S_IDLE: begin
        if (start) begin
          en       = 1'b1;  // Read word 0 right away
          state_nx = S_LOAD;
        end
      end
      S_LOAD: begin
        if (load_done) state_nx = S_PROC;
        else en = 1'b1;
      end
      S_PROC: begin
        en         = 1'b1;
        we         = 1'b1;
        wr_addr_nx = wr_addr + 16'd1;
        if (word_cnt == LAST_WORD) begin
          word_cnt_nx = '0;
          if (last_line) begin
            state_nx = S_DONE;
          end else begin
            line_cnt_nx = line_cnt + 1'b1;
            if (line_cnt == PRE_LAST) begin
              // Last line needs no refill since its bottom row reuses the middle
              last_nx = 1'b1;
              top_nx  = rotate(top_slot);
            end else begin
              state_nx   = S_GAP;
              ld_slot_nx = top_slot;  // Oldest line gets overwritten
            end
          end
        end else begin
          word_cnt_nx = word_cnt + 1'b1;
        end
      end
      S_GAP: state_nx = S_READ;
      S_READ: begin
        if (load_done) begin
          state_nx = S_PROC;
          top_nx   = rotate(top_slot);  // Refilled slot becomes bottom
        end else begin
          en = 1'b1;
        end
      end
      S_DONE: begin
        finish = 1'b1;
        if (!start) begin
          state_nx    = S_IDLE;
          // Rearm every counter and address for the next start
          rd_addr_nx  = '0;
          wr_addr_nx  = WB_ADDR;
          word_cnt_nx = '0;
          line_cnt_nx = '0;
          top_nx      = 2'd0;
          last_nx     = 1'b0;
          ld_slot_nx  = 2'd1;  // Line 0 goes to slot 1 and is mirrored into slot 0
          ld_first_nx = 1'b1;
        end
      end
      default: state_nx = S_IDLE;
    endcase

    // Read issue bookkeeping
    if (en && !we) begin
      rd_addr_nx = rd_addr + 16'd1;
      if (word_cnt == LAST_WORD) begin
        word_cnt_nx = '0;
        if (state == S_LOAD) begin
          ld_slot_nx  = ld_slot + 2'd1;
          ld_first_nx = 1'b0;
        end
      end else begin
        word_cnt_nx = word_cnt + 1'b1;
      end
    end
  end

  // --------------------------------------------------
  // Registers with store strobes one cycle after the issue
  // --------------------------------------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state       <= S_IDLE;
      rd_addr     <= '0;
      wr_addr     <= WB_ADDR;
      word_cnt    <= '0;
      line_cnt    <= '0;
      top_slot    <= 2'd0;
      last_line   <= 1'b0;
      ld_slot     <= 2'd1;
      ld_first    <= 1'b1;
      buf_wr_en   <= 1'b0;
      buf_wr_slot <= 2'd0;
      st_word     <= '0;
      first_line  <= 1'b0;
    end else begin
      state       <= state_nx;
      rd_addr     <= rd_addr_nx;
      wr_addr     <= wr_addr_nx;
      word_cnt    <= word_cnt_nx;
      line_cnt    <= line_cnt_nx;
      top_slot    <= top_nx;
      last_line   <= last_nx;
      ld_slot     <= ld_slot_nx;
      ld_first    <= ld_first_nx;
      buf_wr_en   <= rd_issue;              // dataR valid next cycle
      buf_wr_slot <= ld_slot;
      st_word     <= word_cnt;
      first_line  <= rd_issue && ld_first;
    end
  end

  // Stores and result writes share buf_word_idx and must never overlap
  a_store_not_in_write: assert property (
    @(posedge clk) disable iff (reset) we |-> !buf_wr_en
  );
  // Finish only once every result word is written
  a_finish_all_written: assert property (
    @(posedge clk) disable iff (reset)
      finish |-> (wr_addr == 16'(2 * `ACC_WRITEBACK_ADDR))
  );

endmodule

/* source/line_buffer.sv */
// --------------------------------------------------
// Three-line pixel ring with one border cell per side
// Cell 0 and the last cell copy the end pixels
// Memory is not reset, lines are valid once loaded
// --------------------------------------------------
`timescale 1ns/1ps
`include "acc_consts.svh"

module line_buffer (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 buf_wr_en,
  input  acc_pkg::slot_t       buf_wr_slot,
  input  acc_pkg::word_idx_t   buf_word_idx,
  input  logic                 first_line,
  input  logic                 last_line,
  input  acc_pkg::slot_t       top_slot,
  input  acc_pkg::pixel_word_t dataR,
  output acc_pkg::window_t     window
);

  localparam int CELLS     = `ACC_LINE_LENGTH + 2;  // Pixels plus two borders
  localparam int CELL_BITS = $clog2(CELLS);
  localparam acc_pkg::word_idx_t LAST_WORD =
    acc_pkg::word_idx_t'(`ACC_WORDS_PER_LINE - 1);

  logic [`ACC_PIXEL_BITS-1:0] line_mem [0:2][0:CELLS-1];

  logic [CELL_BITS-1:0] base;        // Cell left of the current word
  acc_pkg::slot_t       above_slot;  // Mirror target on line 0
  acc_pkg::slot_t       mid_slot;
  acc_pkg::slot_t       bot_slot;
  acc_pkg::slot_t       low_slot;    // Slot feeding the bottom window row

  // Word k covers pixel cells 4k+1 .. 4k+4
  assign base = CELL_BITS'({buf_word_idx, 2'b00});

  assign above_slot = (buf_wr_slot == 2'd0) ? 2'd2 : buf_wr_slot - 2'd1;
  assign mid_slot   = (top_slot == 2'd2) ? 2'd0 : top_slot + 2'd1;
  assign bot_slot   = (top_slot == 2'd0) ? 2'd2 : top_slot - 2'd1;
  assign low_slot   = last_line ? mid_slot : bot_slot;  // Bottom edge reuse

  // --------------------------------------------------
  // Write side
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (buf_wr_en) begin
      for (int r = 0; r < 3; r++) begin
        // Own slot, plus the slot above while loading line 0
        if ((r == buf_wr_slot) || (first_line && (r == above_slot))) begin
          for (int i = 0; i < 4; i++) begin
            line_mem[r][base + 1 + i] <= dataR.pix[i];
          end
          if (buf_word_idx == '0)
            line_mem[r][0] <= dataR.pix[0];        // Left border
          if (buf_word_idx == LAST_WORD)
            line_mem[r][CELLS-1] <= dataR.pix[3];  // Right border
        end
      end
    end
  end

  // --------------------------------------------------
  // Read side, six columns around the current word
  // --------------------------------------------------
  always_comb begin
    for (int j = 0; j < 6; j++) begin
      window[0][j] = line_mem[top_slot][base + j];
      window[1][j] = line_mem[mid_slot][base + j];
      window[2][j] = line_mem[low_slot][base + j];
    end
  end

  // Slot 3 does not exist, a store there would be lost
  a_slot_range: assert property (
    @(posedge clk) disable iff (reset) buf_wr_en |-> (buf_wr_slot < 2'd3)
  );

endmodule

/* source/sobel_unit.sv */
// --------------------------------------------------
// Four Sobel magnitudes per cycle, purely combinational
// Magnitude is |gx| + |gy| clamped to 255
// --------------------------------------------------
`timescale 1ns/1ps

module sobel_unit (
  input  acc_pkg::window_t     window,
  output acc_pkg::pixel_word_t result_word
);

  // Zero-extended pixel as a signed operand
  function automatic logic signed [10:0] px(
    input acc_pkg::window_t w,
    input int               row,
    input int               col
  );
    return $signed({3'b000, w[row][col]});
  endfunction

  always_comb begin
    logic signed [10:0] gx;    // Right minus left, +-1020 at most
    logic signed [10:0] gy;    // Top minus bottom
    logic signed [10:0] dx_mid;
    logic signed [10:0] dy_mid;
    logic [10:0]        abs_x;
    logic [10:0]        abs_y;
    logic [11:0]        mag;

    // Output pixel c sits in window column c + 1
    for (int c = 0; c < 4; c++) begin
      // Centre row and column carry weight 2
      dx_mid = px(window, 1, c + 2) - px(window, 1, c);
      dy_mid = px(window, 0, c + 1) - px(window, 2, c + 1);

      gx = px(window, 0, c + 2) - px(window, 0, c)
         + (dx_mid <<< 1)
         + px(window, 2, c + 2) - px(window, 2, c);

      gy = px(window, 0, c) - px(window, 2, c)
         + (dy_mid <<< 1)
         + px(window, 0, c + 2) - px(window, 2, c + 2);

      abs_x = gx[10] ? -gx : gx;
      abs_y = gy[10] ? -gy : gy;
      mag   = {1'b0, abs_x} + {1'b0, abs_y};  // Up to 2040

      result_word.pix[c] = (mag > 12'd255) ? 8'hFF : mag[7:0];  // Saturate
    end
  end

endmodule

/* source/acc_top.sv */
// --------------------------------------------------
// Sobel accelerator top, single shared memory bus
// Memory must be ready every cycle, no handshake
// --------------------------------------------------
`timescale 1ns/1ps

module acc_top (
  input  logic        clk,
  input  logic        reset,
  input  logic        start,
  output logic [15:0] addr,
  output logic        en,
  output logic        we,
  input  logic [31:0] dataR,
  output logic [31:0] dataW,
  output logic        finish
);

  acc_pkg::pixel_word_t rd_word;      // dataR split into pixels
  acc_pkg::pixel_word_t result_word;
  acc_pkg::window_t     window;
  acc_pkg::slot_t       buf_wr_slot;
  acc_pkg::slot_t       top_slot;
  acc_pkg::word_idx_t   buf_word_idx;
  logic                 buf_wr_en;
  logic                 first_line;
  logic                 last_line;

  assign rd_word.word = dataR;
  assign dataW        = result_word.word;  // Valid with the write strobe

  acc_control u_control (
    .clk          (clk),
    .reset        (reset),
    .start        (start),
    .addr         (addr),
    .en           (en),
    .we           (we),
    .finish       (finish),
    .buf_wr_en    (buf_wr_en),
    .buf_wr_slot  (buf_wr_slot),
    .buf_word_idx (buf_word_idx),
    .first_line   (first_line),
    .last_line    (last_line),
    .top_slot     (top_slot)
  );

  line_buffer u_line_buffer (
    .clk          (clk),
    .reset        (reset),
    .buf_wr_en    (buf_wr_en),
    .buf_wr_slot  (buf_wr_slot),
    .buf_word_idx (buf_word_idx),
    .first_line   (first_line),
    .last_line    (last_line),
    .top_slot     (top_slot),
    .dataR        (rd_word),
    .window       (window)
  );

  sobel_unit u_sobel (
    .window      (window),
    .result_word (result_word)
  );

endmodule

/* bench/acc_mem_model.sv */
// --------------------------------------------------
// Word memory for the accelerator bench
// Holds the source image and the result image
// Read data appears one cycle after the address
// Accesses past the end are ignored
// --------------------------------------------------
`timescale 1ns/1ps
`include "acc_consts.svh"

module acc_mem_model (
  input  logic        clk,
  input  logic [15:0] addr,
  input  logic        en,
  input  logic        we,
  input  logic [31:0] dataW,
  output logic [31:0] dataR
);

  // Source region followed by an equal result region
  localparam int DEPTH = 2 * `ACC_WRITEBACK_ADDR;

  logic [31:0] mem [0:DEPTH-1];  // Bench fills and inspects this directly

  initial dataR = '0;  // Defined before the first read

  // --------------------------------------------------
  // Synchronous access, one per cycle
  // --------------------------------------------------
  always @(posedge clk) begin
    if (en) begin
      if (we) begin
        if (addr < DEPTH) mem[addr] <= dataW;
      end else begin
        dataR <= (addr < DEPTH) ? mem[addr] : 32'h0;  // Registered read
      end
    end
  end

endmodule

/* bench/acc_tb.sv */
// --------------------------------------------------
// Bench for the Sobel accelerator top
// Runs a table of images and checks each word by word
// Inputs change 2 ns after the rising edge
// Outputs are sampled on the falling edge
// --------------------------------------------------
`timescale 1ns/1ps
`include "acc_consts.svh"

module acc_tb;

  localparam int LL   = `ACC_LINE_LENGTH;
  localparam int LC   = `ACC_LINE_COUNT;
  localparam int WPL  = `ACC_WORDS_PER_LINE;
  localparam int WB   = `ACC_WRITEBACK_ADDR;
  localparam int NUM_TESTS = 6;
  // Cycle budget of four times the rough cost of all rows
  localparam int TIMEOUT = 4 * NUM_TESTS * 3 * LC * (WPL + 2);

  // Image patterns
  localparam int PAT_FLAT    = 0;
  localparam int PAT_VSTEP   = 1;  // Param is the first bright column
  localparam int PAT_HSTEP   = 2;  // Param is the first bright line
  localparam int PAT_CHECKER = 3;  // Param is the square size
  localparam int PAT_RANDOM  = 4;

  // --------------------------------------------------
  // Test table where -1 skips a count check
  // --------------------------------------------------
  int tbl_pattern [NUM_TESTS] = '{PAT_FLAT, PAT_VSTEP, PAT_HSTEP,
                                  PAT_CHECKER, PAT_RANDOM, PAT_FLAT};
  int tbl_param   [NUM_TESTS] = '{100, 8, 4, 2, 0, 0};
  int tbl_sat     [NUM_TESTS] = '{0, 2 * LC, 2 * LL, -1, -1, 0};   // Pixels at 255
  int tbl_zero    [NUM_TESTS] = '{LL * LC, LL * LC - 2 * LC, LL * LC - 2 * LL,
                                  -1, -1, LL * LC};                // Pixels at 0

  logic        clk;
  logic        reset;
  logic        start;
  logic [15:0] addr;
  logic        en;
  logic        we;
  logic [31:0] dataR;
  logic [31:0] dataW;
  logic        finish;

  int          img [0:LC-1][0:LL-1];  // Current source image
  logic [31:0] src_copy [0:WB-1];     // Source words as loaded
  logic [31:0] lcg_state;
  int          cycle_cnt;
  int          write_cnt;             // Result writes in the current run

  acc_top dut0 (
    .clk    (clk),
    .reset  (reset),
    .start  (start),
    .addr   (addr),
    .en     (en),
    .we     (we),
    .dataR  (dataR),
    .dataW  (dataW),
    .finish (finish)
  );

  acc_mem_model mem0 (
    .clk   (clk),
    .addr  (addr),
    .en    (en),
    .we    (we),
    .dataW (dataW),
    .dataR (dataR)
  );

  always #10 clk = ~clk;  // 20 ns period

  // --------------------------------------------------
  // Helpers
  // --------------------------------------------------
  task automatic stop_with_failure();
    $display("Simulation FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("[FAIL] time %0t: %s is %h, expected %h", $time, name, got, exp);
      stop_with_failure();
    end
  endtask

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // Edge pixel stands in for anything outside the image
  function automatic int pix_at(input int x, input int y);
    int cx;
    int cy;
    cx = (x < 0) ? 0 : (x >= LL) ? LL - 1 : x;
    cy = (y < 0) ? 0 : (y >= LC) ? LC - 1 : y;
    return img[cy][cx];
  endfunction

  // Reference Sobel as |gx| + |gy| saturated
  function automatic int sobel_ref(input int x, input int y);
    int gx;
    int gy;
    int mag;
    gx = (pix_at(x + 1, y - 1) - pix_at(x - 1, y - 1))
       + 2 * (pix_at(x + 1, y) - pix_at(x - 1, y))
       + (pix_at(x + 1, y + 1) - pix_at(x - 1, y + 1));
    gy = (pix_at(x - 1, y - 1) - pix_at(x - 1, y + 1))
       + 2 * (pix_at(x, y - 1) - pix_at(x, y + 1))
       + (pix_at(x + 1, y - 1) - pix_at(x + 1, y + 1));
    mag = ((gx < 0) ? -gx : gx) + ((gy < 0) ? -gy : gy);
    return (mag > 255) ? 255 : mag;
  endfunction

  task automatic build_image(input int pattern, input int param);
    for (int y = 0; y < LC; y++) begin
      for (int x = 0; x < LL; x++) begin
        case (pattern)
          PAT_FLAT:    img[y][x] = param;
          PAT_VSTEP:   img[y][x] = (x >= param) ? 255 : 0;
          PAT_HSTEP:   img[y][x] = (y >= param) ? 255 : 0;
          PAT_CHECKER: img[y][x] = (((x / param) + (y / param)) % 2) ? 255 : 0;
          default: begin
            lcg_state = lcg_next(lcg_state);
            img[y][x] = lcg_state[23:16];  // Upper bits mix better
          end
        endcase
      end
    end
  endtask

  // Source words from the image and a marker fill in the result region
  task automatic load_memory(input int run);
    for (int a = 0; a < WB; a++) begin
      for (int i = 0; i < 4; i++) begin
        src_copy[a][8*i +: 8] = img[a / WPL][4 * (a % WPL) + i];  // Low byte leftmost
      end
      mem0.mem[a] = src_copy[a];
    end
    for (int a = WB; a < 2 * WB; a++) begin
      mem0.mem[a] = {~a[15:0], a[15:0]} ^ (run * 32'h0101_0101);
    end
  endtask

  task automatic check_results(input int t);
    logic [31:0] exp;
    logic [31:0] got;
    int          n_sat;
    int          n_zero;
    n_sat  = 0;
    n_zero = 0;
    for (int y = 0; y < LC; y++) begin
      for (int k = 0; k < WPL; k++) begin
        for (int i = 0; i < 4; i++) exp[8*i +: 8] = sobel_ref(4 * k + i, y);
        got = mem0.mem[WB + y * WPL + k];
        check_value($sformatf("result[%0d]", WB + y * WPL + k), got, exp);
        for (int i = 0; i < 4; i++) begin
          if (got[8*i +: 8] == 8'hFF) n_sat++;
          if (got[8*i +: 8] == 8'h00) n_zero++;
        end
      end
    end
    if (tbl_sat[t] >= 0) check_value("saturated pixel count", n_sat, tbl_sat[t]);
    if (tbl_zero[t] >= 0) check_value("zero pixel count", n_zero, tbl_zero[t]);
    for (int a = 0; a < WB; a++)  // Source must survive the run
      check_value($sformatf("source[%0d]", a), mem0.mem[a], src_copy[a]);
  endtask

  // --------------------------------------------------
  // Timeout and bus monitor
  // --------------------------------------------------
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt > TIMEOUT) begin
      $display("Timeout: no result after %0d cycles", cycle_cnt);
      stop_with_failure();
    end
  end

  always @(negedge clk) begin
    if (!reset && en) begin
      if (we && addr >= 2 * WB) begin
        $display("Write to address %0d past the result region at %0t", addr, $time);
        stop_with_failure();
      end
      if (!we && addr >= WB) begin
        $display("Read from address %0d outside the source image at %0t", addr, $time);
        stop_with_failure();
      end
      if (we) write_cnt <= write_cnt + 1;
    end
  end

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial begin
    clk       = 1'b0;
    reset     = 1'b1;
    start     = 1'b0;
    cycle_cnt = 0;
    write_cnt = 0;
    lcg_state = 32'd18811;
    repeat (10) @(posedge clk);
    #2 reset = 1'b0;

    // Bus stays quiet until start
    repeat (3) begin
      @(negedge clk);
      check_value("en", en, 1'b0);
      check_value("we", we, 1'b0);
      check_value("finish", finish, 1'b0);
    end

    for (int t = 0; t < NUM_TESTS; t++) begin
      build_image(tbl_pattern[t], tbl_param[t]);
      load_memory(t);
      write_cnt = 0;
      @(posedge clk);
      #2 start = 1'b1;
      @(negedge clk);
      while (!finish) @(negedge clk);
      check_value("write count", write_cnt, WPL * LC);
      check_results(t);

      // finish holds and the bus idles while start is high
      repeat (3) begin
        @(negedge clk);
        check_value("finish", finish, 1'b1);
        check_value("en", en, 1'b0);
        check_value("we", we, 1'b0);
      end
      @(posedge clk);
      #2 start = 1'b0;
      @(negedge clk);
      while (finish) @(negedge clk);
      check_value("en", en, 1'b0);
    end

    $display("Simulation PASSED");
    $finish;
  end

endmodule

/* flist.f */
+incdir+source
source/acc_pkg.sv
source/acc_control.sv
source/line_buffer.sv
source/sobel_unit.sv
source/acc_top.sv
bench/acc_mem_model.sv
bench/acc_tb.sv
